/* hw/dcache_pkg.sv */
package dcache_pkg;

  // Fixed geometry of addresses, words and lines
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = LINE_WORDS * WORD_W;
  localparam int LINE_BYTES = LINE_W / 8;
  localparam int WORD_BYTES = WORD_W / 8;
  // Byte offset inside a line, and word offset inside it
  localparam int OFF_W      = $clog2(LINE_BYTES);
  localparam int WORD_OFF_W = $clog2(LINE_WORDS);

  typedef logic [LINE_W-1:0] line_t;

  typedef enum logic {
    LSQ_LOAD  = 1'b0,
    LSQ_STORE = 1'b1
  } lsq_op_e;

  // Source that owns the arrays in the current cycle
  typedef enum logic [2:0] {
    WIN_NONE = 3'd0,
    WIN_INIT = 3'd1,
    WIN_D1   = 3'd2,
    WIN_L2C  = 3'd3,
    WIN_LSQ  = 3'd4
  } d0_winner_e;

  // What d0 does with the arrays, also forwarded to d1
  typedef enum logic [2:0] {
    OP_IDLE        = 3'd0,
    OP_INIT_CLEAR  = 3'd1,
    OP_STORE_WRITE = 3'd2,
    OP_REFILL      = 3'd3,
    OP_LSQ_LOAD    = 3'd4,
    OP_LSQ_STORE   = 3'd5
  } d0_op_e;

  // LSQ request payload, valid travels beside it
  typedef struct packed {
    lsq_op_e                 op;
    logic [ADDR_W-1:0]       addr;
    logic [WORD_W-1:0]       data;
    logic [WORD_BYTES-1:0]   mask;
  } lsq_req_t;

  // Request info latched by d0 for the d1 check
  typedef struct packed {
    d0_op_e                  op;
    logic [ADDR_W-1:0]       addr;
    logic [WORD_W-1:0]       data;
    logic [WORD_BYTES-1:0]   mask;
  } d1_info_t;

endpackage

/* hw/dcache_intf.sv */
`timescale 1ns/10ps

// Link between the d0 and d1 stages
interface d0_d1_if #(
  parameter int N_WAY = 2
);
  localparam int WAY_W = (N_WAY > 1) ? $clog2(N_WAY) : 1;

  // d0 output register
  logic                                 valid;
  dcache_pkg::d1_info_t                 info;
  // d1 status and store write-back
  logic                                 stalled;
  logic                                 wr_valid;
  logic [WAY_W-1:0]                     wr_way;
  logic [dcache_pkg::ADDR_W-1:0]        wr_addr;
  dcache_pkg::line_t                    wr_data;
  logic [dcache_pkg::LINE_BYTES-1:0]    wr_mask;

  modport d0 (output valid, info, input wr_way, wr_addr, wr_data, wr_mask);
  modport d1 (input valid, info, output stalled, wr_valid, wr_way, wr_addr, wr_data, wr_mask);
  // Scheduler only looks at the stall and the write request
  modport ctrl (input stalled, wr_valid);
endinterface

// Port of one single-port array
interface sram_if #(
  parameter int  DEPTH   = 8,
  parameter type entry_t = logic [7:0]
);
  localparam int IDX_W  = $clog2(DEPTH);
  localparam int NBYTES = ($bits(entry_t) + 7) / 8;

  logic               en;
  logic               we;
  logic [IDX_W-1:0]   index;
  logic [NBYTES-1:0]  wmask;
  entry_t             wdata;
  entry_t             rdata;

  modport ctrl (output en, we, index, wmask, wdata);
  modport mem  (input en, we, index, wmask, wdata, output rdata);
  modport rd   (input rdata);
endinterface

/* hw/d0_control.sv */
`timescale 1ns/10ps

module d0_control #(
  parameter  int N_SETS = 8,
  localparam int IDX_W  = $clog2(N_SETS)
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     lsq_valid_i,
  input  dcache_pkg::lsq_op_e      lsq_op_i,
  input  logic                     l2_ans_valid_i,
  output logic                     lsq_ready_o,
  output logic                     l2_ans_ready_o,
  output dcache_pkg::d0_winner_e   winner_o,
  output dcache_pkg::d0_op_e       d0_op_o,
  output logic [IDX_W-1:0]         sweep_index_o,
  d0_d1_if.ctrl                    d01
);

  logic             sweep_q;
  logic [IDX_W-1:0] sweep_idx_q;

  // Init sweep, one set per cycle right after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sweep_q     <= 1'b1;
      sweep_idx_q <= '0;
    end else if (sweep_q) begin
      sweep_idx_q <= sweep_idx_q + 1'b1;
      // Last set cleared
      if (sweep_idx_q == IDX_W'(N_SETS - 1)) begin
        sweep_q <= 1'b0;
      end
    end
  end

  assign sweep_index_o = sweep_idx_q;

  // Fixed priority: sweep, d1 write, L2 answer, LSQ
  always_comb begin
    if (sweep_q) begin
      winner_o = dcache_pkg::WIN_INIT;
    end else if (d01.wr_valid) begin
      winner_o = dcache_pkg::WIN_D1;
    end else if (l2_ans_valid_i) begin
      winner_o = dcache_pkg::WIN_L2C;
    end else if (lsq_valid_i && !d01.stalled) begin
      // LSQ held off while a miss is pending
      winner_o = dcache_pkg::WIN_LSQ;
    end else begin
      winner_o = dcache_pkg::WIN_NONE;
    end
  end

  // Operation of the winning source
  always_comb begin
    case (winner_o)
      dcache_pkg::WIN_INIT: d0_op_o = dcache_pkg::OP_INIT_CLEAR;
      dcache_pkg::WIN_D1:   d0_op_o = dcache_pkg::OP_STORE_WRITE;
      dcache_pkg::WIN_L2C:  d0_op_o = dcache_pkg::OP_REFILL;
      dcache_pkg::WIN_LSQ: begin
        if (lsq_op_i == dcache_pkg::LSQ_STORE) begin
          d0_op_o = dcache_pkg::OP_LSQ_STORE;
        end else begin
          d0_op_o = dcache_pkg::OP_LSQ_LOAD;
        end
      end
      default:              d0_op_o = dcache_pkg::OP_IDLE;
    endcase
  end

  // Readies do not look at their own valid
  assign l2_ans_ready_o = !sweep_q && !d01.wr_valid;
  assign lsq_ready_o    = !sweep_q && !d01.wr_valid && !l2_ans_valid_i && !d01.stalled;

endmodule

/* hw/d0_data_sel.sv */
`timescale 1ns/10ps

module d0_data_sel #(
  parameter  int N_WAY  = 2,
  parameter  int N_SETS = 8,
  localparam int WAY_W  = (N_WAY > 1) ? $clog2(N_WAY) : 1,
  localparam int IDX_W  = $clog2(N_SETS)
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  dcache_pkg::d0_winner_e          winner_i,
  input  dcache_pkg::d0_op_e              d0_op_i,
  input  logic [IDX_W-1:0]                sweep_index_i,
  input  dcache_pkg::lsq_req_t            lsq_req_i,
  input  logic [dcache_pkg::ADDR_W-1:0]   l2_ans_addr_i,
  input  dcache_pkg::line_t               l2_ans_line_i,
  input  logic [WAY_W-1:0]                victim_way_i,
  d0_d1_if.d0                             d01,
  sram_if.ctrl                            tag_o [N_WAY],
  sram_if.ctrl                            data_o [N_WAY]
);

  localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFF_W;

  logic [dcache_pkg::ADDR_W-1:0]      sel_addr;
  logic [IDX_W-1:0]                   sel_index;
  logic [TAG_W:0]                     sel_tag_entry;
  dcache_pkg::line_t                  sel_line;
  logic [dcache_pkg::LINE_BYTES-1:0]  sel_mask;
  logic                               is_refill;
  dcache_pkg::d1_info_t               info_d;
  dcache_pkg::d1_info_t               info_q;
  logic                               valid_q;

  // Address of the winning source
  always_comb begin
    case (winner_i)
      dcache_pkg::WIN_D1:  sel_addr = d01.wr_addr;
      dcache_pkg::WIN_L2C: sel_addr = l2_ans_addr_i;
      dcache_pkg::WIN_LSQ: sel_addr = lsq_req_i.addr;
      default:             sel_addr = '0;
    endcase
  end

  assign is_refill = (d0_op_i == dcache_pkg::OP_REFILL);
  // Sweep walks the sets on its own counter
  assign sel_index = (winner_i == dcache_pkg::WIN_INIT) ? sweep_index_i
                                                         : sel_addr[dcache_pkg::OFF_W +: IDX_W];
  // Refill sets valid, sweep clears it
  assign sel_tag_entry = is_refill ? {1'b1, sel_addr[dcache_pkg::ADDR_W-1 -: TAG_W]} : '0;
  // Full line on refill, masked word on store
  assign sel_line = is_refill ? l2_ans_line_i : d01.wr_data;
  assign sel_mask = is_refill ? '1 : d01.wr_mask;

  for (genvar w = 0; w < N_WAY; w++) begin : g_way
    logic refill_way;
    logic store_way;

    assign refill_way = is_refill && (victim_way_i == WAY_W'(w));
    assign store_way  = (d0_op_i == dcache_pkg::OP_STORE_WRITE) && (d01.wr_way == WAY_W'(w));

    assign tag_o[w].en     = (d0_op_i != dcache_pkg::OP_IDLE);
    assign tag_o[w].we     = (d0_op_i == dcache_pkg::OP_INIT_CLEAR) || refill_way;
    assign tag_o[w].index  = sel_index;
    assign tag_o[w].wmask  = '1;
    assign tag_o[w].wdata  = sel_tag_entry;

    // Data not cleared by the sweep, valid bit covers it
    assign data_o[w].en    = (d0_op_i != dcache_pkg::OP_IDLE);
    assign data_o[w].we    = refill_way || store_way;
    assign data_o[w].index = sel_index;
    assign data_o[w].wmask = sel_mask;
    assign data_o[w].wdata = sel_line;
  end

  always_comb begin
    info_d.op   = d0_op_i;
    info_d.addr = sel_addr;
    info_d.data = lsq_req_i.data;
    info_d.mask = lsq_req_i.mask;
  end

  // d0 output register, cleared on idle cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      info_q  <= '0;
    end else if (d0_op_i != dcache_pkg::OP_IDLE) begin
      valid_q <= 1'b1;
      info_q  <= info_d;
    end else begin
      valid_q <= 1'b0;
      info_q  <= '0;
    end
  end

  assign d01.valid = valid_q;
  assign d01.info  = info_q;

endmodule

/* hw/dcache_sram_bank.sv */
`timescale 1ns/10ps

module dcache_sram_bank #(
  parameter int  DEPTH   = 8,
  parameter type entry_t = logic [7:0]
) (
  input  logic  clk_i,
  sram_if.mem   mem
);

  localparam int W = $bits(entry_t);

  logic [W-1:0] mem_q [DEPTH];
  logic [W-1:0] bit_mask;

  // Byte enables spread over the entry bits
  always_comb begin
    for (int b = 0; b < W; b++) begin
      bit_mask[b] = mem.wmask[b / 8];
    end
  end

  // Read-first single port
  always_ff @(posedge clk_i) begin
    if (mem.en) begin
      if (mem.we) begin
        mem_q[mem.index] <= (mem_q[mem.index] & ~bit_mask) | (mem.wdata & bit_mask);
      end
      mem.rdata <= mem_q[mem.index];
    end
  end

endmodule

/* hw/d1_tag_check.sv */
`timescale 1ns/10ps

module d1_tag_check #(
  parameter  int N_WAY  = 2,
  parameter  int N_SETS = 8,
  localparam int WAY_W  = (N_WAY > 1) ? $clog2(N_WAY) : 1
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  d0_d1_if.d1                             d01,
  sram_if.rd                              tag_i [N_WAY],
  sram_if.rd                              data_i [N_WAY],
  output logic                            l2_req_valid_o,
  output logic [dcache_pkg::ADDR_W-1:0]   l2_req_addr_o,
  input  logic                            l2_req_ready_i,
  input  logic                            l2_ans_fire_i,
  output logic [WAY_W-1:0]                victim_way_o,
  output logic                            lsq_resp_valid_o,
  output logic                            lsq_resp_hit_o,
  output logic [dcache_pkg::WORD_W-1:0]   lsq_resp_data_o
);

  localparam int IDX_W  = $clog2(N_SETS);
  localparam int OFF_W  = dcache_pkg::OFF_W;
  localparam int TAG_W  = dcache_pkg::ADDR_W - IDX_W - OFF_W;
  localparam int LINE_A = dcache_pkg::ADDR_W - OFF_W;

  logic [N_WAY-1:0]                      hit_vec;
  dcache_pkg::line_t                     way_line [N_WAY];
  logic [TAG_W-1:0]                      req_tag;
  logic [dcache_pkg::WORD_OFF_W-1:0]     word_off;
  logic                                  is_load;
  logic                                  is_store;
  logic                                  hit;
  logic                                  load_miss;
  logic [WAY_W-1:0]                      hit_way;
  dcache_pkg::line_t                     hit_line;
  logic                                  miss_q;
  logic                                  req_pend_q;
  logic [LINE_A-1:0]                     miss_line_q;
  logic [IDX_W-1:0]                      miss_idx;
  logic [N_SETS-1:0][WAY_W-1:0]          victim_q;

  assign req_tag  = d01.info.addr[dcache_pkg::ADDR_W-1 -: TAG_W];
  assign word_off = d01.info.addr[OFF_W-1 -: dcache_pkg::WORD_OFF_W];
  assign is_load  = d01.valid && (d01.info.op == dcache_pkg::OP_LSQ_LOAD);
  assign is_store = d01.valid && (d01.info.op == dcache_pkg::OP_LSQ_STORE);

  // Per-way tag compare
  for (genvar w = 0; w < N_WAY; w++) begin : g_cmp
    logic [TAG_W:0] entry;

    assign entry       = tag_i[w].rdata;
    assign hit_vec[w]  = entry[TAG_W] && (entry[TAG_W-1:0] == req_tag);
    assign way_line[w] = data_i[w].rdata;
  end

  // At most one way hits
  always_comb begin
    hit_way  = '0;
    hit_line = '0;
    for (int w = 0; w < N_WAY; w++) begin
      if (hit_vec[w]) begin
        hit_way  = WAY_W'(w);
        hit_line = way_line[w];
      end
    end
  end

  assign hit       = |hit_vec;
  assign load_miss = is_load && !hit;

  // Stall from the miss cycle on, until the refill lands
  assign d01.stalled  = miss_q || load_miss;
  // Store hit goes back to d0 as a masked word write
  assign d01.wr_valid = is_store && hit;
  assign d01.wr_way   = hit_way;
  assign d01.wr_addr  = d01.info.addr;
  assign d01.wr_data  = {dcache_pkg::LINE_WORDS{d01.info.data}};
  assign d01.wr_mask  = dcache_pkg::LINE_BYTES'(d01.info.mask)
                        << (word_off * dcache_pkg::WORD_BYTES);

  // Single miss register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_q     <= 1'b0;
      req_pend_q <= 1'b0;
    end else if (load_miss) begin
      miss_q     <= 1'b1;
      req_pend_q <= 1'b1;
    end else begin
      if (req_pend_q && l2_req_ready_i) begin
        req_pend_q <= 1'b0;
      end
      if (l2_ans_fire_i) begin
        miss_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_miss) begin
      miss_line_q <= d01.info.addr[dcache_pkg::ADDR_W-1:OFF_W];
    end
  end

  assign l2_req_valid_o = req_pend_q;
  assign l2_req_addr_o  = {miss_line_q, {OFF_W{1'b0}}};

  // Refill goes to the set of the pending miss
  assign miss_idx     = miss_line_q[IDX_W-1:0];
  assign victim_way_o = victim_q[miss_idx];

  // Round-robin pointer per set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victim_q <= '0;
    end else if (l2_ans_fire_i) begin
      if (victim_q[miss_idx] == WAY_W'(N_WAY - 1)) begin
        victim_q[miss_idx] <= '0;
      end else begin
        victim_q[miss_idx] <= victim_q[miss_idx] + 1'b1;
      end
    end
  end

  // LSQ response, one edge after the check
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lsq_resp_valid_o <= 1'b0;
      lsq_resp_hit_o   <= 1'b0;
    end else begin
      lsq_resp_valid_o <= is_load || is_store;
      lsq_resp_hit_o   <= hit;
    end
  end

  always_ff @(posedge clk_i) begin
    lsq_resp_data_o <= hit_line[word_off * dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
  end

endmodule

/* hw/dcache_l1_top.sv */
`timescale 1ns/10ps

module dcache_l1_top #(
  parameter int N_WAY  = 2,
  parameter int N_SETS = 8
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // LSQ request
  input  logic                            lsq_req_valid_i,
  input  dcache_pkg::lsq_req_t            lsq_req_i,
  output logic                            lsq_req_ready_o,
  // L2 request
  output logic                            l2_req_valid_o,
  output logic [dcache_pkg::ADDR_W-1:0]   l2_req_addr_o,
  input  logic                            l2_req_ready_i,
  // L2 answer
  input  logic                            l2_ans_valid_i,
  input  logic [dcache_pkg::ADDR_W-1:0]   l2_ans_addr_i,
  input  dcache_pkg::line_t               l2_ans_line_i,
  output logic                            l2_ans_ready_o,
  // Wake-up and response to the LSQ
  output logic                            lsq_wup_valid_o,
  output logic [dcache_pkg::ADDR_W-1:0]   lsq_wup_addr_o,
  output logic                            lsq_resp_valid_o,
  output logic                            lsq_resp_hit_o,
  output logic [dcache_pkg::WORD_W-1:0]   lsq_resp_data_o
);

  localparam int WAY_W = (N_WAY > 1) ? $clog2(N_WAY) : 1;
  localparam int IDX_W = $clog2(N_SETS);
  localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFF_W;

  // Tag array entry depends on the set count
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  dcache_pkg::d0_winner_e  winner;
  dcache_pkg::d0_op_e      d0_op;
  logic [IDX_W-1:0]        sweep_index;
  logic [WAY_W-1:0]        victim_way;
  logic                    l2_ans_fire;

  d0_d1_if #(.N_WAY(N_WAY)) d01 ();
  sram_if #(.DEPTH(N_SETS), .entry_t(tag_entry_t))        tag_if  [N_WAY] ();
  sram_if #(.DEPTH(N_SETS), .entry_t(dcache_pkg::line_t)) data_if [N_WAY] ();

  assign l2_ans_fire     = l2_ans_valid_i && l2_ans_ready_o;
  // LSQ replays on the refilled line address
  assign lsq_wup_valid_o = l2_ans_fire;
  assign lsq_wup_addr_o  = l2_ans_addr_i;

  d0_control #(
    .N_SETS (N_SETS)
  ) u_d0_control (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsq_valid_i    (lsq_req_valid_i),
    .lsq_op_i       (lsq_req_i.op),
    .l2_ans_valid_i (l2_ans_valid_i),
    .lsq_ready_o    (lsq_req_ready_o),
    .l2_ans_ready_o (l2_ans_ready_o),
    .winner_o       (winner),
    .d0_op_o        (d0_op),
    .sweep_index_o  (sweep_index),
    .d01            (d01)
  );

  d0_data_sel #(
    .N_WAY  (N_WAY),
    .N_SETS (N_SETS)
  ) u_d0_data_sel (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .winner_i      (winner),
    .d0_op_i       (d0_op),
    .sweep_index_i (sweep_index),
    .lsq_req_i     (lsq_req_i),
    .l2_ans_addr_i (l2_ans_addr_i),
    .l2_ans_line_i (l2_ans_line_i),
    .victim_way_i  (victim_way),
    .d01           (d01),
    .tag_o         (tag_if),
    .data_o        (data_if)
  );

  // One tag bank and one data bank per way
  for (genvar w = 0; w < N_WAY; w++) begin : g_way
    dcache_sram_bank #(
      .DEPTH   (N_SETS),
      .entry_t (tag_entry_t)
    ) u_tag_bank (
      .clk_i (clk_i),
      .mem   (tag_if[w])
    );

    dcache_sram_bank #(
      .DEPTH   (N_SETS),
      .entry_t (dcache_pkg::line_t)
    ) u_data_bank (
      .clk_i (clk_i),
      .mem   (data_if[w])
    );
  end

  d1_tag_check #(
    .N_WAY  (N_WAY),
    .N_SETS (N_SETS)
  ) u_d1_tag_check (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .d01              (d01),
    .tag_i            (tag_if),
    .data_i           (data_if),
    .l2_req_valid_o   (l2_req_valid_o),
    .l2_req_addr_o    (l2_req_addr_o),
    .l2_req_ready_i   (l2_req_ready_i),
    .l2_ans_fire_i    (l2_ans_fire),
    .victim_way_o     (victim_way),
    .lsq_resp_valid_o (lsq_resp_valid_o),
    .lsq_resp_hit_o   (lsq_resp_hit_o),
    .lsq_resp_data_o  (lsq_resp_data_o)
  );

endmodule

/* sim/tb_dcache_tasks.svh */
`ifndef TB_DCACHE_TASKS_SVH
`define TB_DCACHE_TASKS_SVH

// Result counters
int err_cnt;
int tests_failed;
int errs_at_start;

// Handshake counters, updated by the tracking block
int unsigned acc_cnt;
int unsigned resp_cnt;
int unsigned ans_cnt;
logic        miss_pend;
logic [31:0] miss_addr;

// Reference model of the tag state and of L2 memory
logic             ref_valid [N_SETS][N_WAY];
logic [TAG_W-1:0] ref_tag [N_SETS][N_WAY];
int               ref_rr [N_SETS];
logic [31:0]      stored [logic [31:0]];

function automatic logic [31:0] make_addr(logic [TAG_W-1:0] tag, int set, int word);
  return {tag, IDX_W'(set), 2'(word), 2'b00};
endfunction

// Background content of L2, a hash of the word address
function automatic logic [31:0] seed_word(logic [31:0] addr);
  logic [31:0] a;
  a = {addr[31:2], 2'b00};
  return (a * 32'h9e37_79b1) ^ 32'h3c6e_f372;
endfunction

function automatic logic [31:0] mem_word(logic [31:0] addr);
  logic [31:0] key;
  key = {addr[31:2], 2'b00};
  if (stored.exists(key)) begin
    return stored[key];
  end
  return seed_word(addr);
endfunction

// Write-through, so L2 sees every store
function automatic void merge_store(logic [31:0] addr, logic [31:0] data, logic [3:0] mask);
  logic [31:0] word;
  word = mem_word(addr);
  for (int b = 0; b < 4; b++) begin
    if (mask[b]) begin
      word[b*8 +: 8] = data[b*8 +: 8];
    end
  end
  stored[{addr[31:2], 2'b00}] = word;
endfunction

function automatic logic expect_hit(logic [31:0] addr);
  logic [IDX_W-1:0] set;
  logic             hit;
  set = addr[dcache_pkg::OFF_W +: IDX_W];
  hit = 1'b0;
  for (int w = 0; w < N_WAY; w++) begin
    if (ref_valid[set][w] && ref_tag[set][w] == addr[31 -: TAG_W]) begin
      hit = 1'b1;
    end
  end
  return hit;
endfunction

// Round-robin victim per set
function automatic void note_refill(logic [31:0] addr);
  logic [IDX_W-1:0] set;
  set = addr[dcache_pkg::OFF_W +: IDX_W];
  ref_valid[set][ref_rr[set]] = 1'b1;
  ref_tag[set][ref_rr[set]]   = addr[31 -: TAG_W];
  ref_rr[set]                 = (ref_rr[set] + 1) % N_WAY;
endfunction

function automatic dcache_pkg::line_t build_line(logic [31:0] addr);
  dcache_pkg::line_t line;
  for (int i = 0; i < dcache_pkg::LINE_WORDS; i++) begin
    line[i*32 +: 32] = mem_word({addr[31:4], 4'b0000} + 32'(i * 4));
  end
  return line;
endfunction

// Called on a falling edge, returns on the falling edge after the transfer
task automatic send_req(dcache_pkg::lsq_op_e op, logic [31:0] addr, logic [31:0] data,
                        logic [3:0] mask);
  int unsigned start;
  start                = acc_cnt;
  lsq_req_valid_i      = 1'b1;
  lsq_req_i.op         = op;
  lsq_req_i.addr       = addr;
  lsq_req_i.data       = data;
  lsq_req_i.mask       = mask;
  do begin
    @(negedge clk_i);
  end while (acc_cnt == start);
endtask

task automatic drop_valid();
  lsq_req_valid_i = 1'b0;
endtask

// All responses back and no miss pending
task automatic wait_quiet();
  while (acc_cnt != resp_cnt || miss_pend) begin
    @(negedge clk_i);
  end
endtask

task automatic flag_error(string msg);
  $display("error %0t: %s", $time, msg);
  err_cnt = err_cnt + 1;
endtask

task automatic start_test();
  errs_at_start = err_cnt;
endtask

task automatic finish_test(int num, string name);
  if (err_cnt == errs_at_start) begin
    $display("test %0d %s: passed", num, name);
  end else begin
    tests_failed = tests_failed + 1;
    $display("test %0d %s: failed", num, name);
  end
endtask

`endif

/* sim/tb_dcache_l1.sv */
`timescale 1ns/10ps

module tb_dcache_l1;

  localparam int N_WAY   = 2;
  localparam int N_SETS  = 8;
  localparam int IDX_W   = $clog2(N_SETS);
  localparam int TAG_W   = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFF_W;
  localparam int N_TESTS = 6;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  lsq_req_valid_i;
  dcache_pkg::lsq_req_t  lsq_req_i;
  logic                  lsq_req_ready_o;
  logic                  l2_req_valid_o;
  logic [31:0]           l2_req_addr_o;
  logic                  l2_req_ready_i;
  logic                  l2_ans_valid_i;
  logic [31:0]           l2_ans_addr_i;
  dcache_pkg::line_t     l2_ans_line_i;
  logic                  l2_ans_ready_o;
  logic                  lsq_wup_valid_o;
  logic [31:0]           lsq_wup_addr_o;
  logic                  lsq_resp_valid_o;
  logic                  lsq_resp_hit_o;
  logic [31:0]           lsq_resp_data_o;

  `include "tb_dcache_tasks.svh"

  // Expected response, two stages to match the DUT pipeline
  logic        ex1_valid;
  logic        ex1_hit;
  logic        ex1_load;
  logic        ex1_miss;
  logic        ex2_valid;
  logic        ex2_hit;
  logic        ex2_load;
  logic        ex2_miss;
  logic [31:0] ex1_data;
  logic [31:0] ex2_data;
  logic        req_seen;
  int          post_cnt;

  dcache_l1_top #(
    .N_WAY  (N_WAY),
    .N_SETS (N_SETS)
  ) uut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lsq_req_valid_i  (lsq_req_valid_i),
    .lsq_req_i        (lsq_req_i),
    .lsq_req_ready_o  (lsq_req_ready_o),
    .l2_req_valid_o   (l2_req_valid_o),
    .l2_req_addr_o    (l2_req_addr_o),
    .l2_req_ready_i   (l2_req_ready_i),
    .l2_ans_valid_i   (l2_ans_valid_i),
    .l2_ans_addr_i    (l2_ans_addr_i),
    .l2_ans_line_i    (l2_ans_line_i),
    .l2_ans_ready_o   (l2_ans_ready_o),
    .lsq_wup_valid_o  (lsq_wup_valid_o),
    .lsq_wup_addr_o   (lsq_wup_addr_o),
    .lsq_resp_valid_o (lsq_resp_valid_o),
    .lsq_resp_hit_o   (lsq_resp_hit_o),
    .lsq_resp_data_o  (lsq_resp_data_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Tracks transfers and keeps the reference model in step
  always @(posedge clk_i or negedge rst_ni) begin : track
    logic hit;
    logic is_load;
    if (!rst_ni) begin
      acc_cnt   <= 0;
      resp_cnt  <= 0;
      ans_cnt   <= 0;
      miss_pend <= 1'b0;
      miss_addr <= '0;
      req_seen  <= 1'b0;
      post_cnt  <= 0;
      ex1_valid <= 1'b0;
      ex2_valid <= 1'b0;
      ex1_miss  <= 1'b0;
      ex2_miss  <= 1'b0;
      // Sweep leaves every set empty
      for (int s = 0; s < N_SETS; s++) begin
        ref_rr[s] = 0;
        for (int w = 0; w < N_WAY; w++) begin
          ref_valid[s][w] = 1'b0;
        end
      end
    end else begin
      hit     = expect_hit(lsq_req_i.addr);
      is_load = (lsq_req_i.op == dcache_pkg::LSQ_LOAD);
      if (post_cnt < 255) begin
        post_cnt <= post_cnt + 1;
      end
      ex1_valid <= lsq_req_valid_i && lsq_req_ready_o;
      ex1_hit   <= hit;
      ex1_load  <= is_load;
      ex1_miss  <= lsq_req_valid_i && lsq_req_ready_o && is_load && !hit;
      ex1_data  <= mem_word(lsq_req_i.addr);
      if (lsq_req_valid_i && lsq_req_ready_o) begin
        acc_cnt <= acc_cnt + 1;
        if (!is_load) begin
          merge_store(lsq_req_i.addr, lsq_req_i.data, lsq_req_i.mask);
        end else if (!hit) begin
          miss_pend <= 1'b1;
          miss_addr <= {lsq_req_i.addr[31:4], 4'b0000};
          req_seen  <= 1'b0;
        end
      end
      ex2_valid <= ex1_valid;
      ex2_hit   <= ex1_hit;
      ex2_load  <= ex1_load;
      ex2_miss  <= ex1_miss;
      ex2_data  <= ex1_data;
      if (l2_req_valid_o && l2_req_ready_i) begin
        req_seen <= 1'b1;
      end
      // Refill lands on the L2 answer transfer
      if (l2_ans_valid_i && l2_ans_ready_o) begin
        note_refill(l2_ans_addr_i);
        miss_pend <= 1'b0;
        ans_cnt   <= ans_cnt + 1;
      end
      if (lsq_resp_valid_o) begin
        resp_cnt <= resp_cnt + 1;
      end
    end
  end

  // Init sweep keeps both readies low for N_SETS cycles
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (post_cnt < N_SETS) |-> (!lsq_req_ready_o && !l2_ans_ready_o))
    else flag_error("ready high during the init sweep");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (post_cnt == N_SETS) |-> lsq_req_ready_o)
    else flag_error("LSQ ready still low after the init sweep");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (post_cnt <= N_SETS) |-> (!l2_req_valid_o && !lsq_resp_valid_o && !lsq_wup_valid_o))
    else flag_error("output active right after reset");

  // One response per transfer, two edges later
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsq_resp_valid_o == ex2_valid)
    else flag_error("response valid does not follow the accepted request");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsq_resp_valid_o |-> (lsq_resp_hit_o == ex2_hit))
    else flag_error("response hit flag wrong");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lsq_resp_valid_o && ex2_load && ex2_hit) |-> (lsq_resp_data_o == ex2_data))
    else flag_error("load data differs from the memory model");

  // Miss handling and the single L2 request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex2_miss |-> l2_req_valid_o)
    else flag_error("no L2 request after a load miss");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_req_valid_o |-> (miss_pend && !req_seen && l2_req_addr_o == miss_addr))
    else flag_error("unexpected L2 request or wrong line address");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_pend |-> !lsq_req_ready_o)
    else flag_error("LSQ ready high while a miss is outstanding");

  // No sweep or store write-back overlaps an L2 answer in these tests
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_ans_valid_i |-> l2_ans_ready_o)
    else flag_error("L2 answer not accepted although the arrays are free");
  // Wake-up only in the answer transfer cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsq_wup_valid_o == l2_ans_valid_i)
    else flag_error("wake-up not aligned with the L2 answer");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsq_wup_valid_o |-> (miss_pend && req_seen && lsq_wup_addr_o == miss_addr))
    else flag_error("wake-up without a transferred L2 request or wrong line address");

  // L2 model with random latency
  initial begin : l2_responder
    logic [31:0] req_addr;
    int unsigned start;
    l2_req_ready_i = 1'b0;
    l2_ans_valid_i = 1'b0;
    l2_ans_addr_i  = '0;
    l2_ans_line_i  = '0;
    forever begin
      @(negedge clk_i);
      if (l2_req_valid_o) begin
        req_addr = l2_req_addr_o;
        repeat ($urandom_range(5, 0)) @(negedge clk_i);
        l2_req_ready_i = 1'b1;
        @(negedge clk_i);
        l2_req_ready_i = 1'b0;
        repeat ($urandom_range(5, 0)) @(negedge clk_i);
        start          = ans_cnt;
        l2_ans_valid_i = 1'b1;
        l2_ans_addr_i  = req_addr;
        l2_ans_line_i  = build_line(req_addr);
        do begin
          @(negedge clk_i);
        end while (ans_cnt == start);
        l2_ans_valid_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (N_TESTS * 200) @(posedge clk_i);
    $display("timeout: tests did not finish within %0d cycles", N_TESTS * 200);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    logic [TAG_W-1:0] tag;
    logic [TAG_W-1:0] tags [4];
    logic [31:0]      addr;
    void'($urandom(89322));
    err_cnt         = 0;
    tests_failed    = 0;
    rst_ni          = 1'b0;
    lsq_req_valid_i = 1'b0;
    lsq_req_i       = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    start_test();
    repeat (N_SETS + 2) @(negedge clk_i);
    finish_test(1, "init sweep");

    // Cold load in set 1
    start_test();
    tag  = TAG_W'($urandom());
    addr = make_addr(tag, 1, 2);
    send_req(dcache_pkg::LSQ_LOAD, addr, '0, '0);
    drop_valid();
    wait_quiet();
    finish_test(2, "load miss");

    // Replay after the wake-up, then another word of the line
    start_test();
    send_req(dcache_pkg::LSQ_LOAD, addr, '0, '0);
    send_req(dcache_pkg::LSQ_LOAD, make_addr(tag, 1, 0), '0, '0);
    drop_valid();
    wait_quiet();
    finish_test(3, "refill and replay");

    start_test();
    send_req(dcache_pkg::LSQ_STORE, addr, $urandom(), 4'b0110);
    send_req(dcache_pkg::LSQ_LOAD, addr, '0, '0);
    send_req(dcache_pkg::LSQ_STORE, make_addr(tag, 1, 3), $urandom(), 4'b1001);
    send_req(dcache_pkg::LSQ_LOAD, make_addr(tag, 1, 3), '0, '0);
    // Store miss to a cold set
    send_req(dcache_pkg::LSQ_STORE, make_addr(TAG_W'($urandom()), 3, 1), $urandom(), 4'hf);
    drop_valid();
    wait_quiet();
    repeat (8) @(negedge clk_i);
    finish_test(4, "store hit and store miss");

    // Three lines in set 2 with two ways
    start_test();
    tag = TAG_W'($urandom());
    for (int i = 0; i < N_WAY + 1; i++) begin
      send_req(dcache_pkg::LSQ_LOAD, make_addr(tag + TAG_W'(i), 2, 0), '0, '0);
      drop_valid();
      wait_quiet();
    end
    for (int i = 1; i <= N_WAY + 1; i++) begin
      send_req(dcache_pkg::LSQ_LOAD, make_addr(tag + TAG_W'(i % (N_WAY + 1)), 2, 1), '0, '0);
      drop_valid();
      wait_quiet();
    end
    finish_test(5, "round-robin victim");

    // Warm four sets, then a back-to-back load stream
    start_test();
    for (int s = 0; s < 4; s++) begin
      tags[s] = TAG_W'($urandom());
      send_req(dcache_pkg::LSQ_LOAD, make_addr(tags[s], 4 + s, 0), '0, '0);
      drop_valid();
      wait_quiet();
    end
    for (int i = 0; i < 16; i++) begin
      int s;
      s = int'($urandom_range(3, 0));
      send_req(dcache_pkg::LSQ_LOAD, make_addr(tags[s], 4 + s, int'($urandom_range(3, 0))),
               '0, '0);
    end
    drop_valid();
    wait_quiet();
    finish_test(6, "back-to-back loads");

    $display("%0d tests run, %0d failed, %0d errors", N_TESTS, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+sim
hw/dcache_pkg.sv
hw/dcache_intf.sv
hw/d0_control.sv
hw/d0_data_sel.sv
hw/dcache_sram_bank.sv
hw/d1_tag_check.sv
hw/dcache_l1_top.sv
sim/tb_dcache_l1.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the L1 dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_dcache_l1 --Mdir obj_dir -o tb_dcache_l1 \
  -f compile.f

./obj_dir/tb_dcache_l1 | tee sim.log

# The log decides the result
if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi
